// File: compile.f
core_pkg.sv
exec_if.sv
alu.sv
barrel_shifter.sv
data_mem.sv
writeback.sv
mini_core.sv
tb_mini_core.sv

// File: tb_mini_core.sv
module tb_mini_core;
    timeunit 1ns;
    timeprecision 1ps;

    // the tests need about 200 cycles, the limit leaves a wide margin
    localparam int MAX_CYCLES = 600;

    logic              CLK;
    logic              RESET;
    logic              input_sel;
    core_pkg::data_t   input_1;
    core_pkg::data_t   input_2;
    logic [4:0]        alu_sel;
    logic [2:0]        shift_sel;
    logic [1:0]        op_sel;
    core_pkg::addr_t   addr;
    core_pkg::amt_t    shift_amt;
    logic              mem_sel;
    core_pkg::result_t core_out;

    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'd21633;

    mini_core uut (
        .CLK       (CLK),
        .RESET     (RESET),
        .INPUT_SEL (input_sel),
        .INPUT_1   (input_1),
        .INPUT_2   (input_2),
        .ALU_SEL   (alu_sel),
        .SHIFT_SEL (shift_sel),
        .OP_SEL    (op_sel),
        .ADDR      (addr),
        .SHIFT_AMT (shift_amt),
        .MEM_SEL   (mem_sel),
        .OUTPUT    (core_out)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("run timed out after %0d cycles without finishing", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_operands(output core_pkg::data_t a, output core_pkg::data_t b);
        rng_state = xorshift(rng_state);
        a = rng_state[7:0];
        b = rng_state[23:16];
    endtask

    // expected ALU result, byte-wide results sit in the low byte
    function automatic core_pkg::result_t alu_model(input logic [4:0] op,
                                                    input core_pkg::data_t a,
                                                    input core_pkg::data_t b);
        core_pkg::result_t wa;
        core_pkg::result_t wb;
        core_pkg::result_t r;
        wa = {8'h00, a};
        wb = {8'h00, b};
        case (op)
            core_pkg::ADD:    r = wa + wb;
            core_pkg::SUB:    r = wa - wb;
            core_pkg::MUL:    r = wa * wb;
            core_pkg::AND:    r = {8'h00, a & b};
            core_pkg::NAND:   r = {8'h00, ~(a & b)};
            core_pkg::OR:     r = {8'h00, a | b};
            core_pkg::NOR:    r = {8'h00, ~(a | b)};
            core_pkg::XOR:    r = {8'h00, a ^ b};
            core_pkg::XNOR:   r = {8'h00, ~(a ^ b)};
            core_pkg::NOT_A:  r = {8'h00, ~a};
            core_pkg::NOT_B:  r = {8'h00, ~b};
            core_pkg::EQ:     r = (a == b) ? 16'd1 : 16'd0;
            core_pkg::CAT_AB: r = {a, b};
            core_pkg::CAT_BA: r = {b, a};
            default:          r = 16'd0;
        endcase
        return r;
    endfunction

    // builds the shifted byte one bit at a time from its source position
    function automatic core_pkg::data_t shift_model(input logic [2:0] op,
                                                    input core_pkg::data_t v,
                                                    input core_pkg::amt_t amt);
        core_pkg::data_t r;
        int              n;
        int              src;
        logic            left;
        logic            fill;
        n = amt;
        left = (op == core_pkg::SLL0) || (op == core_pkg::SLL1) ||
               (op == core_pkg::ROL) || (op == core_pkg::ASL);
        case (op)
            core_pkg::SLL1, core_pkg::SRL1: fill = 1'b1;
            core_pkg::ASL:                  fill = v[0];
            core_pkg::ASR:                  fill = v[7];
            default:                        fill = 1'b0;
        endcase
        for (int i = 0; i < 8; i++)
        begin
            src = left ? i - n : i + n;
            if ((op == core_pkg::ROL) || (op == core_pkg::ROR))
                r[i] = v[(src + 8) % 8];
            else if ((src < 0) || (src > 7))
                r[i] = fill;
            else
                r[i] = v[src];
        end
        return r;
    endfunction

    task automatic check_result(input core_pkg::result_t got, input core_pkg::result_t exp,
                                input string what);
        if (got === exp)
            pass_count++;
        else
        begin
            fail_count++;
            $display("Fail at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_shift(input core_pkg::data_t got, input core_pkg::data_t exp,
                               input string what);
        if (got === exp)
            pass_count++;
        else
        begin
            fail_count++;
            $display("Fail at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    // drives one command at a falling edge, returns at the next falling edge
    task automatic issue(input logic [1:0] kind, input logic [4:0] alu_op,
                         input logic [2:0] shift_op, input logic sel,
                         input core_pkg::data_t a, input core_pkg::data_t b,
                         input core_pkg::amt_t amt, input core_pkg::addr_t adr,
                         input logic msel);
        op_sel    = kind;
        alu_sel   = alu_op;
        shift_sel = shift_op;
        input_sel = sel;
        input_1   = a;
        input_2   = b;
        shift_amt = amt;
        addr      = adr;
        mem_sel   = msel;
        @(negedge CLK);
    endtask

    task automatic load_word(input core_pkg::addr_t adr);
        issue(core_pkg::OP_MEM, 5'd0, 3'd0, 1'b0, 8'h00, 8'h00, 3'd0, adr, 1'b0);
    endtask

    task automatic report_test(input string name, input int start);
        $display("%s finished, %0d failed checks", name, fail_count - start);
    endtask

    task automatic test_reset();
        int start;
        start = fail_count;
        check_result(core_out, 16'h0000, "OUTPUT after reset");
        for (int i = 0; i < 16; i++)
        begin
            load_word(4'(i));
            check_result(core_out, 16'h0000, $sformatf("load from address %0d after reset", i));
        end
        report_test("test_reset", start);
    endtask

    task automatic test_alu();
        int              start;
        logic [4:0]      codes [14] = '{0, 1, 2, 5, 6, 7, 8, 9, 10, 11, 12, 13, 15, 16};
        logic [4:0]      unused [4] = '{3, 4, 14, 31};
        core_pkg::data_t a;
        core_pkg::data_t b;
        start = fail_count;
        foreach (codes[i])
        begin
            random_operands(a, b);
            issue(core_pkg::OP_ALU, codes[i], 3'd0, 1'b0, a, b, 3'd0, 4'd0, 1'b0);
            check_result(core_out, alu_model(codes[i], a, b),
                         $sformatf("ALU code %0d on %h and %h", codes[i], a, b));
        end
        // equal operands so EQ also shows a one
        issue(core_pkg::OP_ALU, core_pkg::EQ, 3'd0, 1'b0, a, a, 3'd0, 4'd0, 1'b0);
        check_result(core_out, 16'd1, "EQ on equal operands");
        foreach (unused[i])
        begin
            random_operands(a, b);
            issue(core_pkg::OP_ALU, unused[i], 3'd0, 1'b0, a, b, 3'd0, 4'd0, 1'b0);
            check_result(core_out, 16'h0000, $sformatf("unlisted ALU code %0d", unused[i]));
        end
        report_test("test_alu", start);
    endtask

    task automatic test_shift();
        int              start;
        core_pkg::data_t a;
        core_pkg::data_t b;
        start = fail_count;
        for (int op = 0; op < 8; op++)
        begin
            for (int sel = 0; sel < 2; sel++)
            begin
                for (int amt = 0; amt < 8; amt++)
                begin
                    random_operands(a, b);
                    issue(core_pkg::OP_SHIFT, 5'd0, 3'(op), 1'(sel), a, b, 3'(amt), 4'd0, 1'b0);
                    check_shift(core_out[7:0], shift_model(3'(op), sel ? b : a, 3'(amt)),
                                $sformatf("shift op %0d sel %0d amount %0d", op, sel, amt));
                    check_shift(core_out[15:8], 8'h00, "upper byte of a shift result");
                end
            end
        end
        report_test("test_shift", start);
    endtask

    task automatic test_store_load();
        int                start;
        core_pkg::data_t   a;
        core_pkg::data_t   b;
        core_pkg::result_t shown;
        start = fail_count;
        random_operands(a, b);
        issue(core_pkg::OP_ALU, core_pkg::ADD, 3'd0, 1'b0, a, b, 3'd0, 4'd0, 1'b0);
        shown = alu_model(core_pkg::ADD, a, b);
        check_result(core_out, shown, "ADD before the stores");
        issue(core_pkg::OP_ALU, core_pkg::MUL, 3'd0, 1'b0, a, b, 3'd0, 4'd3, 1'b1);
        check_result(core_out, shown, "OUTPUT held during ALU store");
        issue(core_pkg::OP_SHIFT, 5'd0, core_pkg::ROL, 1'b1, a, b, 3'd5, 4'd9, 1'b1);
        check_result(core_out, shown, "OUTPUT held during shift store");
        issue(core_pkg::OP_MEM, 5'd0, 3'd0, 1'b0, a, b, 3'd0, 4'd12, 1'b1);
        check_result(core_out, shown, "OUTPUT held during operand store");
        // first load reads the word written on the cycle before
        load_word(4'd12);
        check_result(core_out, {8'h00, a}, "load of stored operand");
        load_word(4'd9);
        check_result(core_out, {8'h00, shift_model(core_pkg::ROL, b, 3'd5)},
                     "load of stored shift result");
        load_word(4'd3);
        check_result(core_out, alu_model(core_pkg::MUL, a, b), "load of stored ALU result");
        report_test("test_store_load", start);
    endtask

    task automatic test_reserved();
        int                start;
        core_pkg::data_t   a;
        core_pkg::data_t   b;
        core_pkg::result_t shown;
        start = fail_count;
        random_operands(a, b);
        issue(core_pkg::OP_ALU, core_pkg::ADD, 3'd0, 1'b0, a, b, 3'd0, 4'd0, 1'b0);
        shown = alu_model(core_pkg::ADD, a, b);
        check_result(core_out, shown, "ADD before reserved codes");
        issue(core_pkg::OP_MEM, 5'd0, 3'd0, 1'b0, a, b, 3'd0, 4'd5, 1'b1);
        check_result(core_out, shown, "OUTPUT held during operand store");
        issue(core_pkg::OP_RESERVED, core_pkg::ADD, 3'd0, 1'b0, ~a, ~a, 3'd0, 4'd5, 1'b1);
        check_result(core_out, shown, "OUTPUT after reserved code with MEM_SEL high");
        issue(core_pkg::OP_RESERVED, core_pkg::ADD, 3'd0, 1'b0, ~a, ~a, 3'd0, 4'd5, 1'b0);
        check_result(core_out, shown, "OUTPUT after reserved code with MEM_SEL low");
        load_word(4'd5);
        check_result(core_out, {8'h00, a}, "memory word after reserved codes");
        report_test("test_reserved", start);
    endtask

    task automatic test_back_to_back();
        int                start;
        core_pkg::data_t   a;
        core_pkg::data_t   b;
        core_pkg::data_t   stored;
        core_pkg::result_t exp;
        start = fail_count;
        random_operands(stored, b);
        issue(core_pkg::OP_MEM, 5'd0, 3'd0, 1'b0, stored, b, 3'd0, 4'd7, 1'b1);
        for (int i = 0; i < 6; i++)
        begin
            random_operands(a, b);
            case (i % 3)
                0:
                begin
                    issue(core_pkg::OP_ALU, core_pkg::XOR, 3'd0, 1'b0, a, b, 3'd0, 4'd0, 1'b0);
                    exp = alu_model(core_pkg::XOR, a, b);
                end
                1:
                begin
                    issue(core_pkg::OP_SHIFT, 5'd0, core_pkg::ROR, 1'b0, a, b, 3'(i), 4'd0, 1'b0);
                    exp = {8'h00, shift_model(core_pkg::ROR, a, 3'(i))};
                end
                default:
                begin
                    load_word(4'd7);
                    exp = {8'h00, stored};
                end
            endcase
            check_result(core_out, exp, $sformatf("back-to-back command %0d", i));
        end
        report_test("test_back_to_back", start);
    endtask

    initial
    begin
        RESET     = 1'b1;
        input_sel = 1'b0;
        input_1   = 8'h00;
        input_2   = 8'h00;
        alu_sel   = 5'd0;
        shift_sel = 3'd0;
        op_sel    = core_pkg::OP_RESERVED;
        addr      = 4'd0;
        shift_amt = 3'd0;
        mem_sel   = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        test_reset();
        test_alu();
        test_shift();
        test_store_load();
        test_reserved();
        test_back_to_back();
        $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: mini_core.sv
module mini_core (
    input  logic                                    CLK,
    input  logic                                    RESET,
    input  logic                                    INPUT_SEL,
    input  core_pkg::data_t                         INPUT_1,
    input  core_pkg::data_t                         INPUT_2,
    input  logic [$bits(core_pkg::alu_op_e)-1:0]    ALU_SEL,
    input  logic [$bits(core_pkg::shift_op_e)-1:0]  SHIFT_SEL,
    input  logic [$bits(core_pkg::op_kind_e)-1:0]   OP_SEL,
    input  core_pkg::addr_t                         ADDR,
    input  core_pkg::amt_t                          SHIFT_AMT,
    input  logic                                    MEM_SEL,
    output core_pkg::result_t                       OUTPUT
);

    exec_if cmd ();

    core_pkg::result_t alu_result;
    core_pkg::data_t   shift_result;
    logic              wr_en;
    core_pkg::addr_t   wr_addr;
    core_pkg::result_t wr_data;
    core_pkg::addr_t   rd_addr;
    core_pkg::result_t rd_data;

    // pins straight into the command, select codes cast to their enums
    assign cmd.op_kind   = core_pkg::op_kind_e'(OP_SEL);
    assign cmd.alu_op    = core_pkg::alu_op_e'(ALU_SEL);
    assign cmd.shift_op  = core_pkg::shift_op_e'(SHIFT_SEL);
    assign cmd.operand_1 = INPUT_1;
    assign cmd.operand_2 = INPUT_2;
    assign cmd.input_sel = INPUT_SEL;
    assign cmd.shift_amt = SHIFT_AMT;
    assign cmd.addr      = ADDR;
    assign cmd.mem_sel   = MEM_SEL;

    alu u_alu (
        .cmd        (cmd),
        .alu_result (alu_result)
    );

    barrel_shifter u_shifter (
        .cmd          (cmd),
        .shift_result (shift_result)
    );

    data_mem u_mem (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    writeback u_writeback (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd          (cmd),
        .alu_result   (alu_result),
        .shift_result (shift_result),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr      (rd_addr),
        .result       (OUTPUT)
    );

endmodule

// File: writeback.sv
module writeback (
    input  logic                CLK,
    input  logic                RESET,
    exec_if.unit                cmd,
    input  core_pkg::result_t   alu_result,
    input  core_pkg::data_t     shift_result,
    input  core_pkg::result_t   rd_data,
    output logic                wr_en,
    output core_pkg::addr_t     wr_addr,
    output core_pkg::result_t   wr_data,
    output core_pkg::addr_t     rd_addr,
    output core_pkg::result_t   result
);

    core_pkg::data_t   operand;
    core_pkg::result_t candidate;
    logic              active;
    logic              is_mem;

    assign operand = cmd.input_sel ? cmd.operand_2 : cmd.operand_1;

    // value that a store would write or a compute command would show
    always_comb
    begin
        case (cmd.op_kind)
            core_pkg::OP_ALU:
            begin
                candidate = alu_result;
            end
            core_pkg::OP_SHIFT:
            begin
                candidate = core_pkg::zext(shift_result);
            end
            core_pkg::OP_MEM:
            begin
                candidate = core_pkg::zext(operand);
            end
            default:
            begin
                candidate = '0;
            end
        endcase
    end

    // reserved code touches neither memory nor OUTPUT
    assign active = (cmd.op_kind != core_pkg::OP_RESERVED);
    assign is_mem = (cmd.op_kind == core_pkg::OP_MEM);

    assign wr_en   = active && cmd.mem_sel;
    assign wr_addr = cmd.addr;
    assign wr_data = candidate;
    assign rd_addr = cmd.addr;

    // stores leave the output register alone
    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            result <= '0;
        end
        else if (active && !cmd.mem_sel)
        begin
            result <= is_mem ? rd_data : candidate;
        end
    end

endmodule

// File: data_mem.sv
module data_mem (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                wr_en,
    input  core_pkg::addr_t     wr_addr,
    input  core_pkg::result_t   wr_data,
    input  core_pkg::addr_t     rd_addr,
    output core_pkg::result_t   rd_data
);

    // small register file, every word cleared on reset
    core_pkg::result_t mem [core_pkg::MEM_DEPTH];

    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            for (int i = 0; i < core_pkg::MEM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read is combinational, a write is visible from the next cycle on
    assign rd_data = mem[rd_addr];

endmodule

// File: barrel_shifter.sv
module barrel_shifter (
    exec_if.unit                cmd,
    output core_pkg::data_t     shift_result
);

    core_pkg::data_t operand;
    core_pkg::data_t low_ones;
    core_pkg::data_t high_ones;
    core_pkg::data_t sll0;
    core_pkg::data_t srl0;
    core_pkg::data_t sll1;
    core_pkg::data_t srl1;
    logic [2*core_pkg::DATA_W-1:0] rot_left;
    logic [2*core_pkg::DATA_W-1:0] rot_right;

    assign operand = cmd.input_sel ? cmd.operand_2 : cmd.operand_1;

    // bits vacated by a shift of shift_amt, low end for left and high end for right
    assign low_ones  = ~({core_pkg::DATA_W{1'b1}} << cmd.shift_amt);
    assign high_ones = ~({core_pkg::DATA_W{1'b1}} >> cmd.shift_amt);

    // zero fill
    assign sll0 = operand << cmd.shift_amt;
    assign srl0 = operand >> cmd.shift_amt;

    // one fill
    assign sll1 = sll0 | low_ones;
    assign srl1 = srl0 | high_ones;

    // rotate by shifting a doubled copy, wrapped bits come from the other half
    assign rot_left  = {operand, operand} << cmd.shift_amt;
    assign rot_right = {operand, operand} >> cmd.shift_amt;

    always_comb
    begin
        case (cmd.shift_op)
            core_pkg::SLL0:
            begin
                shift_result = sll0;
            end
            core_pkg::SRL0:
            begin
                shift_result = srl0;
            end
            core_pkg::SLL1:
            begin
                shift_result = sll1;
            end
            core_pkg::SRL1:
            begin
                shift_result = srl1;
            end
            core_pkg::ROL:
            begin
                shift_result = rot_left[2*core_pkg::DATA_W-1 -: core_pkg::DATA_W];
            end
            core_pkg::ROR:
            begin
                shift_result = rot_right[core_pkg::DATA_W-1:0];
            end
            // arithmetic shifts pick the fill from the edge bit
            core_pkg::ASL:
            begin
                shift_result = operand[0] ? sll1 : sll0;
            end
            core_pkg::ASR:
            begin
                shift_result = operand[core_pkg::DATA_W-1] ? srl1 : srl0;
            end
            default:
            begin
                shift_result = '0;
            end
        endcase
    end

endmodule

// File: alu.sv
module alu (
    exec_if.unit                cmd,
    output core_pkg::result_t   alu_result
);

    // operands zero-extended so sums, differences and products keep every bit
    core_pkg::result_t a_wide;
    core_pkg::result_t b_wide;

    assign a_wide = core_pkg::zext(cmd.operand_1);
    assign b_wide = core_pkg::zext(cmd.operand_2);

    always_comb
    begin
        alu_result = '0;
        case (cmd.alu_op)
            core_pkg::ADD:
            begin
                alu_result = a_wide + b_wide;
            end
            // wraps to two's complement when operand_2 is larger
            core_pkg::SUB:
            begin
                alu_result = a_wide - b_wide;
            end
            core_pkg::MUL:
            begin
                alu_result = a_wide * b_wide;
            end

            // bitwise results are one byte wide
            core_pkg::AND:
            begin
                alu_result = core_pkg::zext(cmd.operand_1 & cmd.operand_2);
            end
            core_pkg::NAND:
            begin
                alu_result = core_pkg::zext(~(cmd.operand_1 & cmd.operand_2));
            end
            core_pkg::OR:
            begin
                alu_result = core_pkg::zext(cmd.operand_1 | cmd.operand_2);
            end
            core_pkg::NOR:
            begin
                alu_result = core_pkg::zext(~(cmd.operand_1 | cmd.operand_2));
            end
            core_pkg::XOR:
            begin
                alu_result = core_pkg::zext(cmd.operand_1 ^ cmd.operand_2);
            end
            core_pkg::XNOR:
            begin
                alu_result = core_pkg::zext(~(cmd.operand_1 ^ cmd.operand_2));
            end
            core_pkg::NOT_A:
            begin
                alu_result = core_pkg::zext(~cmd.operand_1);
            end
            core_pkg::NOT_B:
            begin
                alu_result = core_pkg::zext(~cmd.operand_2);
            end

            core_pkg::EQ:
            begin
                alu_result = (cmd.operand_1 == cmd.operand_2) ? core_pkg::result_t'(1) : '0;
            end

            // first named operand lands in the upper byte
            core_pkg::CAT_AB:
            begin
                alu_result = {cmd.operand_1, cmd.operand_2};
            end
            core_pkg::CAT_BA:
            begin
                alu_result = {cmd.operand_2, cmd.operand_1};
            end

            default:
            begin
                alu_result = '0;
            end
        endcase
    end

endmodule

// File: exec_if.sv
interface exec_if;

    // decoded command, valid for the single edge that takes it
    core_pkg::op_kind_e  op_kind;
    core_pkg::alu_op_e   alu_op;
    core_pkg::shift_op_e shift_op;
    core_pkg::data_t     operand_1;
    core_pkg::data_t     operand_2;
    logic                input_sel;
    core_pkg::amt_t      shift_amt;
    core_pkg::addr_t     addr;
    logic                mem_sel;

    // execution units only look at the command
    modport unit (
        input op_kind, alu_op, shift_op,
        input operand_1, operand_2, input_sel,
        input shift_amt, addr, mem_sel
    );

    // top level fills it in from the pins
    modport source (
        output op_kind, alu_op, shift_op,
        output operand_1, operand_2, input_sel,
        output shift_amt, addr, mem_sel
    );

endinterface

// File: core_pkg.sv
package core_pkg;

    // operand, address and shift amount widths
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 4;
    localparam int AMT_W     = 3;

    // results and memory words hold a full product
    localparam int RES_W     = 2 * DATA_W;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [RES_W-1:0]  result_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [AMT_W-1:0]  amt_t;

    // command kind, taken from OP_SEL
    typedef enum logic [1:0] {
        OP_ALU      = 2'd0,
        OP_SHIFT    = 2'd1,
        OP_RESERVED = 2'd2,
        OP_MEM      = 2'd3
    } op_kind_e;

    // codes 3, 4, 14 and 17 and up are unused and give zero
    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        MUL    = 5'd2,
        AND    = 5'd5,
        NAND   = 5'd6,
        OR     = 5'd7,
        NOR    = 5'd8,
        XOR    = 5'd9,
        XNOR   = 5'd10,
        NOT_A  = 5'd11,
        NOT_B  = 5'd12,
        EQ     = 5'd13,
        CAT_AB = 5'd15,
        CAT_BA = 5'd16
    } alu_op_e;

    // shifter function, the 0/1 suffix is the fill value
    typedef enum logic [2:0] {
        SLL0 = 3'd0,
        SRL0 = 3'd1,
        SLL1 = 3'd2,
        SRL1 = 3'd3,
        ROL  = 3'd4,
        ROR  = 3'd5,
        ASL  = 3'd6,
        ASR  = 3'd7
    } shift_op_e;

    // widen an operand to a result word with zeros in the upper byte
    function automatic result_t zext(input data_t value);
        result_t wide;
        wide = {{(RES_W - DATA_W){1'b0}}, value};
        return wide;
    endfunction

endpackage
